// File: Makefile
VERILATOR ?= verilator
TOP ?= histTb
FILELIST ?= compile.f
OBJDIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FILELIST))
SIMBIN := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIMBIN)

$(SIMBIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: compile.f
histPkg.sv
histRam.sv
histBuilder.sv
peakFinder.sv
histTop.sv
histTopSva.sv
histTb.sv

// File: histBuilder.sv
module histBuilder #(
    parameter int BIN_WIDTH = histPkg::BIN_WIDTH,
    parameter int COUNT_WIDTH = histPkg::COUNT_WIDTH,
    parameter int HITS_PER_FRAME = histPkg::HITS_PER_FRAME
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    input  logic                   hitValid,
    input  logic [BIN_WIDTH-1:0]   hitBin,
    input  logic [COUNT_WIDTH-1:0] rdData,
    input  logic [BIN_WIDTH-1:0]   scanAddr,
    input  logic                   scanDone,
    output logic                   busy,
    output logic                   collecting,
    output logic                   wrEn,
    output logic [BIN_WIDTH-1:0]   wrAddr,
    output logic [COUNT_WIDTH-1:0] wrData,
    output logic [BIN_WIDTH-1:0]   rdAddr,
    output logic                   scanStart
);

    localparam int HIT_COUNT_WIDTH = $clog2(HITS_PER_FRAME + 1);
    localparam logic [BIN_WIDTH-1:0] LAST_BIN = '1;
    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;
    localparam logic [HIT_COUNT_WIDTH-1:0] LAST_HIT = HIT_COUNT_WIDTH'(HITS_PER_FRAME - 1);

    histPkg::builderState_t state;
    histPkg::builderState_t nextState;

    // clear address and accepted hits of this frame
    logic [BIN_WIDTH-1:0]       clrAddr;
    logic [HIT_COUNT_WIDTH-1:0] hitCount;
    logic                       hitAccept;
    logic                       lastHit;

    // hit whose read is returning this cycle
    logic                 pipeValid;
    logic [BIN_WIDTH-1:0] pipeBin;

    // bin and count written in the previous cycle
    logic                   fwdValid;
    logic [BIN_WIDTH-1:0]   fwdBin;
    logic [COUNT_WIDTH-1:0] fwdCount;

    // read-modify-write datapath
    logic [COUNT_WIDTH-1:0] oldCount;
    logic [COUNT_WIDTH-1:0] newCount;

    // hits only count while collecting
    assign hitAccept = hitValid && (state == histPkg::builderCollect);
    assign lastHit = hitAccept && (hitCount == LAST_HIT);

    always_comb begin
        nextState = state;
        case (state)
            histPkg::builderIdle: begin
                if (start) begin
                    nextState = histPkg::builderClear;
                end
            end
            histPkg::builderClear: begin
                if (clrAddr == LAST_BIN) begin
                    nextState = histPkg::builderCollect;
                end
            end
            histPkg::builderCollect: begin
                if (lastHit) begin
                    nextState = histPkg::builderDrain;
                end
            end
            // one cycle for the final write
            histPkg::builderDrain: begin
                nextState = histPkg::builderScan;
            end
            histPkg::builderScan: begin
                // busy is already low with the result so a start here is taken
                if (scanDone) begin
                    nextState = start ? histPkg::builderClear : histPkg::builderIdle;
                end
            end
            default: begin
                nextState = histPkg::builderIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= histPkg::builderIdle;
            clrAddr <= '0;
            hitCount <= '0;
            pipeValid <= 1'b0;
            fwdValid <= 1'b0;
            scanStart <= 1'b0;
        end else begin
            state <= nextState;
            pipeValid <= hitAccept;
            // forwarding only ever comes from a hit write
            fwdValid <= pipeValid;
            // pulse in the first scan cycle
            scanStart <= (state == histPkg::builderDrain);
            // wraps back to zero after the last bin
            if (state == histPkg::builderClear) begin
                clrAddr <= clrAddr + 1'b1;
            end
            if (state == histPkg::builderClear) begin
                hitCount <= '0;
            end else if (hitAccept) begin
                hitCount <= hitCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pipeBin <= hitBin;
        fwdBin <= pipeBin;
        fwdCount <= newCount;
    end

    // memory still holds the old count when the same bin was just written
    assign oldCount = (fwdValid && (fwdBin == pipeBin)) ? fwdCount : rdData;
    // saturating increment
    assign newCount = (oldCount == COUNT_MAX) ? oldCount : oldCount + 1'b1;

    // write port is shared by clear and increment
    always_comb begin
        if (state == histPkg::builderClear) begin
            wrEn = 1'b1;
            wrAddr = clrAddr;
            wrData = '0;
        end else begin
            wrEn = pipeValid;
            wrAddr = pipeBin;
            wrData = newCount;
        end
    end

    // hit reads issue in the same cycle as the strobe
    assign rdAddr = (state == histPkg::builderScan) ? scanAddr : hitBin;

    assign collecting = (state == histPkg::builderCollect);
    // drops together with the result pulse
    assign busy = (state != histPkg::builderIdle) && !scanDone;

endmodule

// File: histPkg.sv
package histPkg;

    // bin index bits by default
    // six bits give 64 bins
    localparam int BIN_WIDTH = 6;

    // width of one bin count
    localparam int COUNT_WIDTH = 8;

    // accepted hits that close one frame
    localparam int HITS_PER_FRAME = 200;

    // frame sequencing of the histogram builder
    typedef enum logic [2:0] {
        // waiting for a start pulse
        builderIdle,
        // zero one bin per cycle
        builderClear,
        // take hits and increment bins
        builderCollect,
        // last increment still in flight
        builderDrain,
        // peak search owns the read port
        builderScan
    } builderState_t;

    // peak search sequencing
    typedef enum logic [1:0] {
        // waiting for scanStart
        scanIdle,
        // bin 0 loads the running maximum
        scanPrime,
        // one bin compared per cycle
        scanCompare,
        // result pulse
        scanFinish
    } scanState_t;

endpackage

// File: histRam.sv
module histRam #(
    parameter int BIN_WIDTH = histPkg::BIN_WIDTH,
    parameter int COUNT_WIDTH = histPkg::COUNT_WIDTH
) (
    input  logic                   clk,
    input  logic                   wrEn,
    input  logic [BIN_WIDTH-1:0]   wrAddr,
    input  logic [COUNT_WIDTH-1:0] wrData,
    input  logic [BIN_WIDTH-1:0]   rdAddr,
    output logic [COUNT_WIDTH-1:0] rdData
);

    // one count per bin
    localparam int DEPTH = 2 ** BIN_WIDTH;

    // block memory style array
    logic [COUNT_WIDTH-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read
    // same address as the write returns the old count
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: histTb.sv
module histTb;
    timeunit 1ns;
    timeprecision 100ps;

    // small memory so saturation and the scan stay short
    localparam int BIN_WIDTH = 4;
    localparam int COUNT_WIDTH = 4;
    localparam int HITS_PER_FRAME = 40;
    localparam int BINS = 2 ** BIN_WIDTH;
    localparam int COUNT_MAX = 2 ** COUNT_WIDTH - 1;
    // cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   res;
    logic                   start;
    logic                   hitValid;
    logic [BIN_WIDTH-1:0]   hitBin;
    logic                   busy;
    logic                   collecting;
    logic                   peakValid;
    logic [BIN_WIDTH-1:0]   peakBin;
    logic [COUNT_WIDTH-1:0] peakCount;

    // reference histogram of the current frame
    int modelCount [BINS];
    int modelHits;
    bit modelOpen;

    histTop #(
        .BIN_WIDTH(BIN_WIDTH),
        .COUNT_WIDTH(COUNT_WIDTH),
        .HITS_PER_FRAME(HITS_PER_FRAME)
    ) UUT (
        .clk(clk),
        .res(res),
        .start(start),
        .hitValid(hitValid),
        .hitBin(hitBin),
        .busy(busy),
        .collecting(collecting),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // drive point just after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkBin(input string name, input logic [BIN_WIDTH-1:0] actual,
                            input logic [BIN_WIDTH-1:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic checkCount(input string name, input logic [COUNT_WIDTH-1:0] actual,
                              input logic [COUNT_WIDTH-1:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, actual, expected));
        end
    endtask

    function automatic void clearModel();
        for (int i = 0; i < BINS; i++) begin
            modelCount[i] = 0;
        end
        modelHits = 0;
        modelOpen = 1'b0;
    endfunction

    // one strobe, then idle cycles
    task automatic sendHit(input logic [BIN_WIDTH-1:0] bin, input int gap);
        hitValid = 1'b1;
        hitBin = bin;
        // only the first HITS_PER_FRAME strobes of the window count
        if (modelOpen && (modelHits < HITS_PER_FRAME)) begin
            if (modelCount[bin] < COUNT_MAX) begin
                modelCount[bin]++;
            end
            modelHits++;
        end
        nextCycle();
        hitValid = 1'b0;
        repeat (gap) nextCycle();
    endtask

    task automatic startFrame();
        int waited;
        waited = 0;
        while (busy) begin
            nextCycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("busy never dropped before a new frame");
            end
        end
        clearModel();
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        if (!busy) begin
            failRun("busy did not rise the cycle after start");
        end
        // clear phase walks every bin first
        waited = 0;
        while (!collecting) begin
            nextCycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("clear phase never reached collecting");
            end
        end
        modelOpen = 1'b1;
    endtask

    task automatic checkFrameClosed();
        if (collecting) begin
            failRun("collecting still high after the last hit of the frame");
        end
        modelOpen = 1'b0;
    endtask

    task automatic waitPeak();
        int waited;
        int bestBin;
        int bestCount;
        // strictly greater keeps the lowest index on a tie
        bestBin = 0;
        bestCount = modelCount[0];
        for (int i = 1; i < BINS; i++) begin
            if (modelCount[i] > bestCount) begin
                bestBin = i;
                bestCount = modelCount[i];
            end
        end
        waited = 0;
        while (!peakValid) begin
            nextCycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("no peak result arrived after the frame");
            end
        end
        if (busy) begin
            failRun("busy still high in the peak result cycle");
        end
        checkBin("peakBin", peakBin, BIN_WIDTH'(bestBin));
        checkCount("peakCount", peakCount, COUNT_WIDTH'(bestCount));
        // result must stay after the pulse
        nextCycle();
        checkBin("peakBin", peakBin, BIN_WIDTH'(bestBin));
        checkCount("peakCount", peakCount, COUNT_WIDTH'(bestCount));
    endtask

    task automatic checkResetState();
        if (busy || collecting || peakValid) begin
            failRun("a control output is high after reset");
        end
        checkBin("peakBin", peakBin, '0);
        checkCount("peakCount", peakCount, '0);
    endtask

    task automatic singleBinFrame();
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            sendHit(4'd9, 1 + (i % 2));
        end
        checkFrameClosed();
        waitPeak();
    endtask

    // runs of one bin, then plain alternation
    // peak count of bins 1 and 6 only comes out right through forwarding
    task automatic backToBackFrame();
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            if (i < 24) begin
                sendHit(BIN_WIDTH'(((i / 3) % 2) * 5 + 1), 0);
            end else begin
                sendHit((i % 2) ? 4'd12 : 4'd13, 0);
            end
        end
        checkFrameClosed();
        waitPeak();
    endtask

    // bins 11 and 3 end equal, higher index filled first
    task automatic tieFrame();
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            if (i < 10) begin
                sendHit(4'd11, 0);
            end else if (i < 20) begin
                sendHit(4'd3, 1);
            end else if (i < 28) begin
                sendHit(4'd7, 0);
            end else begin
                sendHit(BIN_WIDTH'(i % 2), 0);
            end
        end
        checkFrameClosed();
        waitPeak();
    endtask

    task automatic clearBetweenFrames();
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            sendHit(4'd5, 0);
        end
        checkFrameClosed();
        waitPeak();
        // old counts in bin 5 must be gone
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            sendHit(BIN_WIDTH'(i % 8), 1);
        end
        checkFrameClosed();
        waitPeak();
    endtask

    task automatic droppedHitsFrame();
        // strobes while idle
        for (int i = 0; i < 5; i++) begin
            sendHit(4'd14, 0);
        end
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            // start in the middle of collect
            start = (i == 10);
            sendHit(BIN_WIDTH'((i % 4) + 1), 0);
        end
        start = 1'b0;
        checkFrameClosed();
        // strobes in drain and scan
        // a single one counted would lift bin 2 above bin 1
        for (int i = 0; i < 6; i++) begin
            sendHit(4'd2, 0);
        end
        waitPeak();
    endtask

    task automatic randomFrame();
        startFrame();
        for (int i = 0; i < HITS_PER_FRAME; i++) begin
            sendHit(BIN_WIDTH'($urandom % BINS), int'($urandom % 3));
        end
        checkFrameClosed();
        waitPeak();
    endtask

    initial begin
        void'($urandom(64449));
        res = 1'b0;
        start = 1'b0;
        hitValid = 1'b0;
        hitBin = '0;
        clearModel();
        repeat (10) @(posedge clk);
        #2;
        res = 1'b1;
        checkResetState();
        singleBinFrame();
        backToBackFrame();
        tieFrame();
        clearBetweenFrames();
        droppedHitsFrame();
        randomFrame();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: histTop.sv
module histTop #(
    parameter int BIN_WIDTH = histPkg::BIN_WIDTH,
    parameter int COUNT_WIDTH = histPkg::COUNT_WIDTH,
    parameter int HITS_PER_FRAME = histPkg::HITS_PER_FRAME
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    input  logic                   hitValid,
    input  logic [BIN_WIDTH-1:0]   hitBin,
    output logic                   busy,
    output logic                   collecting,
    output logic                   peakValid,
    output logic [BIN_WIDTH-1:0]   peakBin,
    output logic [COUNT_WIDTH-1:0] peakCount
);

    // memory write port
    logic                   wrEn;
    logic [BIN_WIDTH-1:0]   wrAddr;
    logic [COUNT_WIDTH-1:0] wrData;

    // memory read port
    logic [BIN_WIDTH-1:0]   rdAddr;
    logic [COUNT_WIDTH-1:0] rdData;

    // peak search handshake
    logic [BIN_WIDTH-1:0] scanAddr;
    logic                 scanStart;
    logic                 scanDone;

    histRam #(
        .BIN_WIDTH(BIN_WIDTH),
        .COUNT_WIDTH(COUNT_WIDTH)
    ) uRam (
        .clk(clk),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdAddr(rdAddr),
        .rdData(rdData)
    );

    // owns the write port and muxes the read address
    histBuilder #(
        .BIN_WIDTH(BIN_WIDTH),
        .COUNT_WIDTH(COUNT_WIDTH),
        .HITS_PER_FRAME(HITS_PER_FRAME)
    ) uBuilder (
        .clk(clk),
        .res(res),
        .start(start),
        .hitValid(hitValid),
        .hitBin(hitBin),
        .rdData(rdData),
        .scanAddr(scanAddr),
        .scanDone(scanDone),
        .busy(busy),
        .collecting(collecting),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdAddr(rdAddr),
        .scanStart(scanStart)
    );

    peakFinder #(
        .BIN_WIDTH(BIN_WIDTH),
        .COUNT_WIDTH(COUNT_WIDTH)
    ) uPeak (
        .clk(clk),
        .res(res),
        .scanStart(scanStart),
        .rdData(rdData),
        .scanAddr(scanAddr),
        .scanDone(scanDone),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

endmodule

// File: histTopSva.sv
module histTopSva (
    input logic                   clk,
    input logic                   res,
    input logic                   busy,
    input logic                   collecting,
    input logic                   peakValid,
    input logic                   wrEn,
    input histPkg::builderState_t builderState
);
    timeunit 1ns;
    timeprecision 100ps;

    // result is a single-cycle pulse
    peakPulse: assert property (@(posedge clk) disable iff (!res)
        peakValid |=> !peakValid)
        else $error("peakValid high for more than one cycle");

    collectBusy: assert property (@(posedge clk) disable iff (!res)
        collecting |-> busy)
        else $error("collecting without busy");

    // memory is only written in clear or by a hit
    idleNoWrite: assert property (@(posedge clk) disable iff (!res)
        (builderState == histPkg::builderIdle) |-> !wrEn)
        else $error("memory write while idle");

    // busy drops exactly with the result
    busyFall: assert property (@(posedge clk) disable iff (!res)
        $fell(busy) |-> peakValid)
        else $error("busy fell without peakValid");

    // busy was still high right before the result
    peakBusyFall: assert property (@(posedge clk) disable iff (!res)
        peakValid |-> $fell(busy))
        else $error("peakValid without busy falling");

endmodule

bind histTop histTopSva uSva (
    .clk(clk),
    .res(res),
    .busy(busy),
    .collecting(collecting),
    .peakValid(peakValid),
    .wrEn(wrEn),
    .builderState(uBuilder.state)
);

// File: peakFinder.sv
module peakFinder #(
    parameter int BIN_WIDTH = histPkg::BIN_WIDTH,
    parameter int COUNT_WIDTH = histPkg::COUNT_WIDTH
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   scanStart,
    input  logic [COUNT_WIDTH-1:0] rdData,
    output logic [BIN_WIDTH-1:0]   scanAddr,
    output logic                   scanDone,
    output logic                   peakValid,
    output logic [BIN_WIDTH-1:0]   peakBin,
    output logic [COUNT_WIDTH-1:0] peakCount
);

    localparam logic [BIN_WIDTH-1:0] LAST_BIN = '1;

    histPkg::scanState_t state;

    // bin of the count on rdData
    logic [BIN_WIDTH-1:0] dataAddr;

    // running maximum
    logic [BIN_WIDTH-1:0]   maxBin;
    logic [COUNT_WIDTH-1:0] maxCount;

    // strictly greater so the lower bin keeps a tie
    logic                   greater;
    logic [BIN_WIDTH-1:0]   bestBin;
    logic [COUNT_WIDTH-1:0] bestCount;

    assign greater = (rdData > maxCount);
    assign bestBin = greater ? dataAddr : maxBin;
    assign bestCount = greater ? rdData : maxCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= histPkg::scanIdle;
            scanAddr <= '0;
            dataAddr <= '0;
            peakBin <= '0;
            peakCount <= '0;
        end else begin
            // read latency is one cycle
            dataAddr <= scanAddr;
            case (state)
                histPkg::scanIdle: begin
                    // bin 0 is read in the start cycle
                    if (scanStart) begin
                        scanAddr <= scanAddr + 1'b1;
                        state <= histPkg::scanPrime;
                    end
                end
                histPkg::scanPrime: begin
                    scanAddr <= scanAddr + 1'b1;
                    state <= histPkg::scanCompare;
                end
                histPkg::scanCompare: begin
                    if (dataAddr == LAST_BIN) begin
                        // park at bin 0 for the next frame
                        scanAddr <= '0;
                        peakBin <= bestBin;
                        peakCount <= bestCount;
                        state <= histPkg::scanFinish;
                    end else begin
                        scanAddr <= scanAddr + 1'b1;
                    end
                end
                histPkg::scanFinish: begin
                    state <= histPkg::scanIdle;
                end
                default: begin
                    state <= histPkg::scanIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // first count taken as is
        if (state == histPkg::scanPrime) begin
            maxBin <= dataAddr;
            maxCount <= rdData;
        end else if (state == histPkg::scanCompare) begin
            maxBin <= bestBin;
            maxCount <= bestCount;
        end
    end

    // one cycle after the last compare
    assign scanDone = (state == histPkg::scanFinish);
    assign peakValid = (state == histPkg::scanFinish);

endmodule
